//--- channel_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module channel_ctrl (
	input wire clk,
	input wire rst,
	input wire start,
	input wire fetcher_done,
	input wire in_empty,
	input wire credit_ok,
	input wire prod_valid,
	input wire acc_busy,
	output logic in_rd_en,
	output logic acc_clear,
	output logic flush_req,
	output logic done,
	output spmv_pkg::channel_state_e state
);

	spmv_pkg::channel_state_e state_next;
	logic stream_over;

	// Source drained and the last product already taken by the accumulator
	assign stream_over = fetcher_done && in_empty && !prod_valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= spmv_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			spmv_pkg::ST_IDLE: begin
				if (start) begin
					state_next = spmv_pkg::ST_RUN;
				end
			end
			spmv_pkg::ST_RUN: begin
				if (stream_over) begin
					state_next = spmv_pkg::ST_FLUSH;
				end
			end
			spmv_pkg::ST_FLUSH: begin
				// One cycle is enough to push out the open row
				state_next = spmv_pkg::ST_DONE;
			end
			spmv_pkg::ST_DONE: begin
				if (!start) begin
					state_next = spmv_pkg::ST_IDLE;
				end
			end
			default: begin
				state_next = spmv_pkg::ST_IDLE;
			end
		endcase
	end

	////////////////////////////////////////
	// Control strobes
	////////////////////////////////////////

	// Pop only with data present and a free output slot promised
	assign in_rd_en = (state == spmv_pkg::ST_RUN) && !in_empty && credit_ok;

	// Single pulse on the way from idle into a new run
	assign acc_clear = (state == spmv_pkg::ST_IDLE) && start;

	assign flush_req = (state == spmv_pkg::ST_FLUSH) && acc_busy;

	assign done = (state == spmv_pkg::ST_DONE);

endmodule

`default_nettype wire

//--- credit_counter.sv
`timescale 1ns/100ps
`default_nettype none

module credit_counter #(
	parameter int DEPTH = 8
) (
	input wire clk,
	input wire rst,
	input wire acc_clear,
	input wire take,
	input wire give_merge,
	input wire give_pop,
	input wire [$clog2(DEPTH):0] occupancy,
	output logic credit_ok
);

	localparam int CNT_BITS = $clog2(DEPTH) + 1;

	logic [CNT_BITS-1:0] count;
	logic [CNT_BITS-1:0] take_ext;
	logic [CNT_BITS-1:0] merge_ext;
	logic [CNT_BITS-1:0] pop_ext;

	assign take_ext = {{(CNT_BITS-1){1'b0}}, take};
	assign merge_ext = {{(CNT_BITS-1){1'b0}}, give_merge};
	assign pop_ext = {{(CNT_BITS-1){1'b0}}, give_pop};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= CNT_BITS'(DEPTH);
		end else if (acc_clear) begin
			// Rows still waiting in the FIFO keep their slots
			count <= CNT_BITS'(DEPTH) - occupancy + pop_ext;
		end else begin
			count <= count + merge_ext + pop_ext - take_ext;
		end
	end

	assign credit_ok = (count != '0);

endmodule

`default_nettype wire

//--- out_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module out_fifo #(
	parameter int DEPTH = 8
) (
	input wire clk,
	input wire rst,
	input wire we,
	input wire [spmv_pkg::PROD_BITS-1:0] din_data,
	input wire [spmv_pkg::ROW_ID_BITS-1:0] din_addr,
	input wire rd_en,
	output logic [spmv_pkg::PROD_BITS-1:0] data_out,
	output logic [spmv_pkg::ROW_ID_BITS-1:0] addr_out,
	output logic empty,
	output logic [$clog2(DEPTH):0] occupancy
);

	localparam int AW = $clog2(DEPTH);

	logic [spmv_pkg::PROD_BITS-1:0] mem_data [DEPTH];
	logic [spmv_pkg::ROW_ID_BITS-1:0] mem_addr [DEPTH];
	logic [AW-1:0] wp;
	logic [AW-1:0] rp;
	logic gb;
	logic rd_fire;

	assign rd_fire = rd_en && !empty;

	always_ff @(posedge clk) begin
		if (we) begin
			mem_data[wp] <= din_data;
			mem_addr[wp] <= din_addr;
		end
	end

	// Guard bit tells full from empty when the pointers meet
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wp <= '0;
			rp <= '0;
			gb <= 1'b0;
		end else begin
			if (we) begin
				wp <= wp + 1'b1;
			end
			if (rd_fire) begin
				rp <= rp + 1'b1;
			end
			if (we && !rd_fire && (AW'(wp + 1'b1) == rp)) begin
				gb <= 1'b1;
			end else if (rd_fire && !we) begin
				gb <= 1'b0;
			end
		end
	end

	// Head word shown without a read cycle
	assign data_out = mem_data[rp];
	assign addr_out = mem_addr[rp];
	assign empty = (wp == rp) && !gb;
	assign occupancy = gb ? (AW + 1)'(DEPTH) : {1'b0, AW'(wp - rp)};

endmodule

`default_nettype wire

//--- product_stage.sv
`timescale 1ns/100ps
`default_nettype none

module product_stage (
	input wire clk,
	input wire rst,
	input wire in_rd_en,
	input wire [spmv_pkg::MAT_VAL_BITS-1:0] mat_val,
	input wire [spmv_pkg::VEC_VAL_BITS-1:0] vec_val,
	input wire [spmv_pkg::ROW_ID_BITS-1:0] row_id,
	output logic prod_valid,
	output logic [spmv_pkg::PROD_BITS-1:0] prod,
	output logic [spmv_pkg::ROW_ID_BITS-1:0] prod_row
);

	logic [spmv_pkg::PROD_BITS-1:0] mat_ext;
	logic [spmv_pkg::PROD_BITS-1:0] vec_ext;

	// Operands widened to the full product width
	assign mat_ext = {{spmv_pkg::VEC_VAL_BITS{1'b0}}, mat_val};
	assign vec_ext = {{spmv_pkg::MAT_VAL_BITS{1'b0}}, vec_val};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prod_valid <= 1'b0;
		end else begin
			prod_valid <= in_rd_en;
		end
	end

	// Row id rides along with its product
	always_ff @(posedge clk) begin
		if (in_rd_en) begin
			prod <= mat_ext * vec_ext;
			prod_row <= row_id;
		end
	end

endmodule

`default_nettype wire

//--- row_accumulator.sv
`timescale 1ns/100ps
`default_nettype none

module row_accumulator (
	input wire clk,
	input wire rst,
	input wire acc_clear,
	input wire flush_req,
	input wire prod_valid,
	input wire [spmv_pkg::PROD_BITS-1:0] prod,
	input wire [spmv_pkg::ROW_ID_BITS-1:0] prod_row,
	output logic merge,
	output logic acc_busy,
	output logic fifo_we,
	output logic [spmv_pkg::PROD_BITS-1:0] fifo_data,
	output logic [spmv_pkg::ROW_ID_BITS-1:0] fifo_addr
);

	logic row_open;
	logic [spmv_pkg::ROW_ID_BITS-1:0] open_row;
	logic [spmv_pkg::PROD_BITS-1:0] sum;
	logic same_row;
	logic close_row;

	assign same_row = row_open && (prod_row == open_row);

	// Open row leaves on a row change or at the end of the stream
	assign close_row = row_open && ((prod_valid && !same_row) || flush_req);

	assign acc_busy = prod_valid || row_open;

	////////////////////////////////////////
	// Row tracking and output strobes
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			row_open <= 1'b0;
			merge <= 1'b0;
			fifo_we <= 1'b0;
		end else if (acc_clear) begin
			row_open <= 1'b0;
			merge <= 1'b0;
			fifo_we <= 1'b0;
		end else begin
			merge <= prod_valid && same_row;
			fifo_we <= close_row;
			if (prod_valid) begin
				row_open <= 1'b1;
			end else if (flush_req) begin
				row_open <= 1'b0;
			end
		end
	end

	// Running sum wraps at the product width
	always_ff @(posedge clk) begin
		if (close_row) begin
			fifo_data <= sum;
			fifo_addr <= open_row;
		end
		if (prod_valid) begin
			open_row <= prod_row;
			if (same_row) begin
				sum <= sum + prod;
			end else begin
				sum <= prod;
			end
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/bash
# Build the channel testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_spmv_channel -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Regression passed$" \
	&& echo "Simulation PASSED" \
	|| { echo "Simulation FAILED"; exit 1; }

//--- spmv_channel.sv
`timescale 1ns/100ps
`default_nettype none

module spmv_channel #(
	parameter int DEPTH = spmv_pkg::FIFO_DEPTH
) (
	input wire clk,
	input wire rst,
	input wire start,
	input wire fetcher_done,
	input wire [spmv_pkg::MAT_VAL_BITS-1:0] mat_val,
	input wire [spmv_pkg::VEC_VAL_BITS-1:0] vec_val,
	input wire [spmv_pkg::ROW_ID_BITS-1:0] row_id,
	input wire in_empty,
	output wire in_rd_en,
	output wire [spmv_pkg::PROD_BITS-1:0] data_out,
	output wire [spmv_pkg::ROW_ID_BITS-1:0] addr_out,
	output wire out_empty,
	input wire out_rd_en,
	output wire done
);

	wire credit_ok;
	wire acc_clear;
	wire flush_req;
	wire acc_busy;
	wire merge;
	wire pop;
	wire prod_valid;
	wire [spmv_pkg::PROD_BITS-1:0] prod;
	wire [spmv_pkg::ROW_ID_BITS-1:0] prod_row;
	wire fifo_we;
	wire [spmv_pkg::PROD_BITS-1:0] fifo_data;
	wire [spmv_pkg::ROW_ID_BITS-1:0] fifo_addr;
	wire [$clog2(DEPTH):0] occupancy;
	spmv_pkg::channel_state_e state;

	// Pops requested on an empty FIFO are dropped
	assign pop = out_rd_en && !out_empty;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	channel_ctrl u_ctrl (
		.clk(clk), .rst(rst), .start(start), .fetcher_done(fetcher_done),
		.in_empty(in_empty), .credit_ok(credit_ok), .prod_valid(prod_valid),
		.acc_busy(acc_busy), .in_rd_en(in_rd_en), .acc_clear(acc_clear),
		.flush_req(flush_req), .done(done), .state(state)
	);

	credit_counter #(.DEPTH(DEPTH)) u_credit (
		.clk(clk), .rst(rst), .acc_clear(acc_clear), .take(in_rd_en),
		.give_merge(merge), .give_pop(pop), .occupancy(occupancy),
		.credit_ok(credit_ok)
	);

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	product_stage u_prod (
		.clk(clk), .rst(rst), .in_rd_en(in_rd_en), .mat_val(mat_val),
		.vec_val(vec_val), .row_id(row_id), .prod_valid(prod_valid),
		.prod(prod), .prod_row(prod_row)
	);

	row_accumulator u_acc (
		.clk(clk), .rst(rst), .acc_clear(acc_clear), .flush_req(flush_req),
		.prod_valid(prod_valid), .prod(prod), .prod_row(prod_row),
		.merge(merge), .acc_busy(acc_busy), .fifo_we(fifo_we),
		.fifo_data(fifo_data), .fifo_addr(fifo_addr)
	);

	out_fifo #(.DEPTH(DEPTH)) u_fifo (
		.clk(clk), .rst(rst), .we(fifo_we), .din_data(fifo_data),
		.din_addr(fifo_addr), .rd_en(out_rd_en), .data_out(data_out),
		.addr_out(addr_out), .empty(out_empty), .occupancy(occupancy)
	);

endmodule

`default_nettype wire

//--- spmv_channel_props.sv
`timescale 1ns/100ps
`default_nettype none

module spmv_channel_props #(
	parameter int DEPTH = 8
) (
	input wire clk,
	input wire rst,
	input wire in_rd_en,
	input wire in_empty,
	input wire done,
	input wire [1:0] state,
	input wire fifo_we,
	input wire [$clog2(DEPTH):0] occupancy
);

	// Source is only popped when it holds an entry
	assert property (@(posedge clk) disable iff (rst) in_rd_en |-> !in_empty)
		else $error("in_rd_en high while in_empty is high");

	assert property (@(posedge clk) disable iff (rst) done |-> state == spmv_pkg::ST_DONE)
		else $error("done high outside ST_DONE");

	// Credits must keep a full FIFO from being written
	assert property (@(posedge clk) disable iff (rst)
		fifo_we |-> occupancy != ($clog2(DEPTH) + 1)'(DEPTH))
		else $error("out_fifo written while full");

endmodule

bind spmv_channel spmv_channel_props #(.DEPTH(DEPTH)) u_props (
	.clk(clk), .rst(rst), .in_rd_en(in_rd_en), .in_empty(in_empty),
	.done(done), .state(state), .fifo_we(fifo_we), .occupancy(occupancy)
);

`default_nettype wire

//--- spmv_pkg.sv
`default_nettype none

package spmv_pkg;

	////////////////////////////////////////
	// Data widths
	////////////////////////////////////////

	localparam int MAT_VAL_BITS = 8;
	localparam int VEC_VAL_BITS = 8;
	localparam int ROW_ID_BITS = 8;

	// Width of a product and of a row sum
	localparam int PROD_BITS = MAT_VAL_BITS + VEC_VAL_BITS;

	// Output FIFO depth as a power of two
	localparam int FIFO_DEPTH = 8;

	////////////////////////////////////////
	// Controller states
	////////////////////////////////////////

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_RUN   = 2'd1,
		ST_FLUSH = 2'd2,
		ST_DONE  = 2'd3
	} channel_state_e;

endpackage

`default_nettype wire

//--- spmv_stimulus.txt
// kind a b c, hex. kind 1 = entry (mat vec row), 2 = expected row (sum row 0),
// kind 3 = end of test (out_rd_en hold cycles 0 0)
// Single-entry rows
1 03 05 01
1 10 10 02
1 ff ff 03
1 07 09 05
2 000f 01 0
2 0100 02 0
2 fe01 03 0
2 003f 05 0
3 0 0 0
// Merged runs, row 11 wraps past 16 bits
1 02 03 10
1 04 05 10
1 ff ff 11
1 ff ff 11
1 02 02 11
1 0a 0a 10
2 001a 10 0
2 fc06 11 0
2 0064 10 0
3 0 0 0
// Back-pressure with ten rows, first row repeats the last row id above
1 03 03 10
1 01 02 20
1 02 02 21
1 03 03 21
1 04 04 22
1 05 06 23
1 0b 0b 24
1 10 20 25
1 20 20 26
1 20 20 26
1 30 02 27
1 08 09 28
2 0009 10 0
2 0002 20 0
2 000d 21 0
2 0010 22 0
2 001e 23 0
2 0079 24 0
2 0200 25 0
2 0800 26 0
2 0060 27 0
2 0048 28 0
3 3c 0 0
// Fresh run starting on the previous last row
1 01 01 28
1 09 09 2a
1 01 00 2a
2 0001 28 0
2 0051 2a 0
3 0 0 0

//--- tb.f
spmv_pkg.sv
channel_ctrl.sv
credit_counter.sv
product_stage.sv
row_accumulator.sv
out_fifo.sv
spmv_channel.sv
spmv_channel_props.sv
tb_spmv_channel.sv

//--- tb_spmv_channel.sv
`timescale 1ns/100ps
`default_nettype none

module tb_spmv_channel;

	localparam int MEM_WORDS = 512;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic fetcher_done;
	logic [spmv_pkg::MAT_VAL_BITS-1:0] mat_val;
	logic [spmv_pkg::VEC_VAL_BITS-1:0] vec_val;
	logic [spmv_pkg::ROW_ID_BITS-1:0] row_id;
	logic in_empty;
	logic out_rd_en;
	wire in_rd_en;
	wire [spmv_pkg::PROD_BITS-1:0] data_out;
	wire [spmv_pkg::ROW_ID_BITS-1:0] addr_out;
	wire out_empty;
	wire done;

	logic [15:0] stim [MEM_WORDS];
	logic [15:0] lfsr;
	int cycles = 0;
	int cycle_limit;
	int rec;
	int exp_total;
	int popped;
	int hold;
	logic gap;
	logic done_s;
	logic empty_s;

	// Entries as {mat, vec, row}, expected rows as {sum, row}
	logic [23:0] src_q [$];
	logic [23:0] exp_q [$];

	spmv_channel #(.DEPTH(spmv_pkg::FIFO_DEPTH)) u_dut (
		.clk(clk), .rst(rst), .start(start), .fetcher_done(fetcher_done),
		.mat_val(mat_val), .vec_val(vec_val), .row_id(row_id),
		.in_empty(in_empty), .in_rd_en(in_rd_en), .data_out(data_out),
		.addr_out(addr_out), .out_empty(out_empty), .out_rd_en(out_rd_en),
		.done(done)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: run still busy after %0d cycles", cycles);
			$display("Regression failed");
			$fatal(1, "Stopping on timeout");
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic take_bit(output logic b);
		lfsr = lfsr_next(lfsr);
		b = lfsr[0];
	endtask

	task automatic stop_run;
		$display("Regression failed");
		$fatal(1, "Stopping at the first error");
	endtask

	function automatic int count_entries();
		int i;
		int n;
		i = 0;
		n = 0;
		while (i < MEM_WORDS && stim[i] != 16'h0) begin
			if (stim[i] == 16'h1) begin
				n++;
			end
			i += 4;
		end
		return n;
	endfunction

	task automatic collect_test;
		logic [15:0] kind;
		popped = 0;
		exp_total = 0;
		kind = stim[rec*4];
		while (kind != 16'h3) begin
			if (kind == 16'h1) begin
				src_q.push_back({stim[rec*4+1][7:0], stim[rec*4+2][7:0], stim[rec*4+3][7:0]});
			end else if (kind == 16'h2) begin
				exp_q.push_back({stim[rec*4+1], stim[rec*4+2][7:0]});
				exp_total++;
			end else begin
				$display("Stimulus record %0d has unknown kind %h", rec, kind);
				stop_run();
			end
			rec++;
			kind = stim[rec*4];
		end
		hold = int'(stim[rec*4+1]);
		rec++;
	endtask

	task automatic drive_source;
		in_empty = (src_q.size() == 0) || gap;
		if (src_q.size() != 0) begin
			{mat_val, vec_val, row_id} = src_q[0];
		end else begin
			{mat_val, vec_val, row_id} = '0;
		end
	endtask

	task automatic check_pop;
		logic [23:0] want;
		assert (exp_q.size() != 0) else begin
			$display("Row %h popped at %0t with no row left to expect", addr_out, $time);
			stop_run();
		end
		want = exp_q.pop_front();
		popped++;
		assert (popped < exp_total || fetcher_done) else begin
			$display("Last row of the test came out before fetcher_done");
			stop_run();
		end
		assert (data_out == want[23:8]) else begin
			$display("FAILED at %0t: data_out = %h, expected %h", $time, data_out, want[23:8]);
			stop_run();
		end
		assert (addr_out == want[7:0]) else begin
			$display("FAILED at %0t: addr_out = %h, expected %h", $time, addr_out, want[7:0]);
			stop_run();
		end
	endtask

	// Sample at the falling edge, drive 2 ns after the rising edge
	task automatic cycle_step(input logic hold_out);
		logic took;
		logic b0;
		logic b1;
		@(negedge clk);
		took = in_rd_en;
		done_s = done;
		empty_s = out_empty;
		if (out_rd_en && !out_empty) begin
			check_pop();
		end
		@(posedge clk);
		#2;
		if (took) begin
			void'(src_q.pop_front());
		end
		take_bit(b0);
		take_bit(b1);
		gap = b0 && b1;
		take_bit(b0);
		take_bit(b1);
		out_rd_en = !hold_out && !(b0 && b1);
		drive_source();
	endtask

	task automatic run_test;
		int n;
		n = 0;
		start = 1'b1;
		fetcher_done = 1'b0;
		drive_source();
		while (src_q.size() != 0) begin
			cycle_step(n < hold);
			n++;
		end
		// Keep the last row open a while before the stream ends
		repeat (6) begin
			cycle_step(n < hold);
			n++;
		end
		fetcher_done = 1'b1;
		while (!done_s) begin
			cycle_step(1'b0);
		end
		while (exp_q.size() != 0) begin
			cycle_step(1'b0);
			assert (done_s) else begin
				$display("done fell at %0t while start was still high", $time);
				stop_run();
			end
		end
		repeat (4) begin
			cycle_step(1'b0);
			assert (empty_s && done_s) else begin
				$display("Extra output or lost done after the test drained at %0t", $time);
				stop_run();
			end
		end
		start = 1'b0;
		cycle_step(1'b0);
		cycle_step(1'b0);
		assert (!done_s) else begin
			$display("done stayed high after start was lowered");
			stop_run();
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		rst = 1'b1;
		start = 1'b0;
		fetcher_done = 1'b0;
		mat_val = '0;
		vec_val = '0;
		row_id = '0;
		in_empty = 1'b1;
		out_rd_en = 1'b0;
		lfsr = 16'd39;
		gap = 1'b0;
		done_s = 1'b0;
		empty_s = 1'b1;
		cycle_limit = 0;
		foreach (stim[i]) begin
			stim[i] = 16'h0;
		end
		$readmemh("spmv_stimulus.txt", stim);
		assert (count_entries() != 0) else begin
			$display("No entry records found in spmv_stimulus.txt");
			stop_run();
		end
		cycle_limit = 20 * count_entries() + 200;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		rec = 0;
		while (stim[rec*4] != 16'h0) begin
			collect_test();
			run_test();
		end
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire
